// File: Bender.yml
package:
  name: fv_bank

sources:
  - hdl/fv_bank_pkg.sv
  - hdl/fv_sram_bank.sv
  - hdl/fv_stream_engine.sv
  - hdl/fv_access_engine.sv
  - hdl/fv_bank_arbiter.sv
  - hdl/fv_bank_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/fv_bank_tb.sv

// File: compile.f
hdl/fv_bank_pkg.sv
hdl/fv_sram_bank.sv
hdl/fv_stream_engine.sv
hdl/fv_access_engine.sv
hdl/fv_bank_arbiter.sv
hdl/fv_bank_top.sv
test/tb_clock_gen.sv
test/fv_bank_tb.sv

// File: hdl/fv_access_engine.sv
/* Write-back bursts and tagged edge-PE reads in the access view of the address.
   The source holds an ungranted request and sends nothing new during a burst. */
`timescale 1ns/1ps
`default_nettype none

module fv_access_engine (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [fv_bank_pkg::FV_NUM_W-1:0]    fv_num,
    input  wire fv_bank_pkg::out_req_t         req,
    input  wire                                grant,
    input  wire [fv_bank_pkg::FV_DATA_W-1:0]   rdata,
    output logic                               want,
    output fv_bank_pkg::sram_req_t             sram,
    output fv_bank_pkg::edge_rd_beat_t         edge_out
);
    import fv_bank_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR,
        ST_RD
    } state_t;

    state_t                 state;
    logic [LINE_W-1:0]      line_cnt;
    logic [NODE_ID_W-1:0]   node_q;
    logic [PE_TAG_W-1:0]    tag_q;
    logic [LINE_W:0]        lines_q;

    logic                   accept;
    logic                   rd_issue;
    logic                   rd_last;
    logic [LINE_W:0]        req_lines;

    logic                   beat_valid;
    logic                   beat_sos;
    logic                   beat_eos;

    assign req_lines = fv_num_lines(fv_num);
    assign want      = (state != ST_IDLE) || req.valid;
    assign accept    = (state == ST_IDLE) && grant && req.valid;

    always_comb begin
        sram.cen                      = 1'b1;
        sram.wen                      = 1'b1;
        sram.addr.access_view.node_id = node_q;
        sram.addr.access_view.line    = line_cnt;
        sram.wdata                    = req.data;
        rd_issue                      = 1'b0;
        rd_last                       = 1'b0;
        case (state)
            ST_IDLE: begin
                // First line of either burst goes out in the accept cycle
                if (accept) begin
                    sram.cen                      = 1'b0;
                    sram.wen                      = ~req.rd_wr;
                    sram.addr.access_view.node_id = req.node_id;
                    sram.addr.access_view.line    = '0;
                    rd_issue                      = ~req.rd_wr;
                    rd_last                       = (req_lines == (LINE_W+1)'(1));
                end
            end
            ST_WR: begin
                if (grant && req.valid) begin
                    sram.cen = 1'b0;
                    sram.wen = 1'b0;
                end
            end
            ST_RD: begin
                if (grant) begin
                    sram.cen = 1'b0;
                    rd_issue = 1'b1;
                    rd_last  = ({1'b0, line_cnt} == lines_q - 1'b1);
                end
            end
            default: begin
                sram.cen = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            line_cnt   <= '0;
            beat_valid <= 1'b0;
            beat_sos   <= 1'b0;
            beat_eos   <= 1'b0;
        end else begin
            beat_valid <= rd_issue;
            beat_sos   <= rd_issue && (state == ST_IDLE);
            beat_eos   <= rd_issue && rd_last;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        line_cnt <= LINE_W'(1);
                        if (req.rd_wr) begin
                            state <= req.wr_eos ? ST_IDLE : ST_WR;
                        end else begin
                            state <= rd_last ? ST_IDLE : ST_RD;
                        end
                    end
                end
                ST_WR: begin
                    if (grant && req.valid) begin
                        line_cnt <= line_cnt + 1'b1;
                        if (req.wr_eos) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RD: begin
                    if (grant) begin
                        line_cnt <= line_cnt + 1'b1;
                        if (rd_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Burst context, taken from the accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            node_q  <= req.node_id;
            tag_q   <= req.pe_tag;
            lines_q <= req_lines;
        end
    end

    always_comb begin
        edge_out.valid  = beat_valid;
        edge_out.sos    = beat_sos;
        edge_out.eos    = beat_eos;
        edge_out.pe_tag = tag_q;
        edge_out.data   = rdata;
    end

    // No back-pressure, so the source stays quiet while a read burst runs
    no_req_in_read: assert property (@(posedge clk) disable iff (reset)
        state == ST_RD |-> !req.valid)
        else $error("New access request during an edge read burst");

    // Write-back beats come back to back until wr_eos
    wr_beats_contiguous: assert property (@(posedge clk) disable iff (reset)
        state == ST_WR |-> req.valid && req.rd_wr)
        else $error("Gap or read inside a write-back burst");

endmodule

`default_nettype wire

// File: hdl/fv_bank_arbiter.sv
/* Hands the single SRAM port to one engine, by the LSB of the update iteration.
   The owner keeps the bank until its want falls, so a mode change never cuts a burst. */
`timescale 1ns/1ps
`default_nettype none

module fv_bank_arbiter (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [fv_bank_pkg::UPD_W-1:0]     update_iter,
    input  wire                              stream_want,
    input  wire                              access_want,
    input  wire fv_bank_pkg::sram_req_t      stream_sram,
    input  wire fv_bank_pkg::sram_req_t      access_sram,
    output logic                             stream_grant,
    output logic                             access_grant,
    output fv_bank_pkg::sram_req_t           sram
);
    import fv_bank_pkg::*;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_STREAM,
        OWN_ACCESS
    } owner_t;

    owner_t owner;
    logic   odd_iter;
    logic   free;

    // Even iterations stream, odd iterations serve write-back and edge reads
    assign odd_iter = update_iter[0];

    // Bank is free once the owner drops its want
    assign free = (owner == OWN_NONE) ||
                  ((owner == OWN_STREAM) && !stream_want) ||
                  ((owner == OWN_ACCESS) && !access_want);

    assign stream_grant = stream_want && ((owner == OWN_STREAM) || (free && !odd_iter));
    assign access_grant = access_want && ((owner == OWN_ACCESS) || (free && odd_iter));

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= OWN_NONE;
        end else if (stream_grant) begin
            owner <= OWN_STREAM;
        end else if (access_grant) begin
            owner <= OWN_ACCESS;
        end else begin
            owner <= OWN_NONE;
        end
    end

    always_comb begin
        if (stream_grant) begin
            sram = stream_sram;
        end else if (access_grant) begin
            sram = access_sram;
        end else begin
            sram       = '0;
            sram.cen   = 1'b1;
            sram.wen   = 1'b1;
        end
    end

    one_grant: assert property (@(posedge clk) disable iff (reset)
        !(stream_grant && access_grant))
        else $error("Both engines granted the SRAM");

endmodule

`default_nettype wire

// File: hdl/fv_bank_pkg.sv
/* Widths and port structs shared by the feature-value bank.
   A line holds two 32-bit features and a node owns at most 8 lines (fv_num 1 to 16). */
`default_nettype none

package fv_bank_pkg;

    localparam int FV_DATA_W      = 64;
    localparam int ITER_W         = 2;
    localparam int NODE_W         = 3;
    localparam int LINE_W         = 3;
    localparam int NODE_ID_W      = ITER_W + NODE_W;
    localparam int FV_NUM_W       = 5;
    localparam int PE_TAG_W       = 2;
    localparam int UPD_W          = 4;
    localparam int ADDR_W         = ITER_W + NODE_W + LINE_W;
    localparam int NODES_PER_ITER = 1 << NODE_W;

    // Stream engine view of an SRAM address
    typedef struct packed {
        logic [ITER_W-1:0] iter;
        logic [NODE_W-1:0] node;
        logic [LINE_W-1:0] line;
    } fv_stream_addr_t;

    // Access engine view, global node id is iteration and node together
    typedef struct packed {
        logic [NODE_ID_W-1:0] node_id;
        logic [LINE_W-1:0]    line;
    } fv_access_addr_t;

    typedef union packed {
        fv_stream_addr_t stream_view;
        fv_access_addr_t access_view;
    } fv_addr_u;

    // Enables are active low
    typedef struct packed {
        logic                 cen;
        logic                 wen;
        fv_addr_u             addr;
        logic [FV_DATA_W-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 rd_wr;
        logic                 wr_eos;
        logic [NODE_ID_W-1:0] node_id;
        logic [PE_TAG_W-1:0]  pe_tag;
        logic [FV_DATA_W-1:0] data;
    } out_req_t;

    typedef struct packed {
        logic                      valid;
        logic                      sos;
        logic                      eos;
        logic [NODE_W+LINE_W-1:0]  a;
        logic [FV_DATA_W-1:0]      data;
    } sm_fv_beat_t;

    typedef struct packed {
        logic                 valid;
        logic                 sos;
        logic                 eos;
        logic [PE_TAG_W-1:0]  pe_tag;
        logic [FV_DATA_W-1:0] data;
    } edge_rd_beat_t;

    // Lines per node is half the feature count rounded up
    function automatic logic [LINE_W:0] fv_num_lines(input logic [FV_NUM_W-1:0] num);
        logic [FV_NUM_W:0] sum;
        sum = {1'b0, num} + 1'b1;
        return sum[LINE_W+1:1];
    endfunction

endpackage

`default_nettype wire

// File: hdl/fv_bank_top.sv
/* One feature-value SRAM bank with its stream engine, access engine and arbiter.
   Outputs cannot be stalled; sources hold requests that are not granted. */
`timescale 1ns/1ps
`default_nettype none

module fv_bank_top (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [fv_bank_pkg::ITER_W-1:0]      replay_iter,
    input  wire [fv_bank_pkg::UPD_W-1:0]       update_iter,
    input  wire [fv_bank_pkg::FV_NUM_W-1:0]    fv_num,
    input  wire                                stream_begin,
    input  wire fv_bank_pkg::out_req_t         req,
    output fv_bank_pkg::sm_fv_beat_t           sm_out,
    output fv_bank_pkg::edge_rd_beat_t         edge_out
);
    import fv_bank_pkg::*;

    logic                  stream_want;
    logic                  access_want;
    logic                  stream_grant;
    logic                  access_grant;
    sram_req_t             stream_sram;
    sram_req_t             access_sram;
    sram_req_t             sram_req;
    logic [FV_DATA_W-1:0]  rdata;

    fv_stream_engine u_stream (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .fv_num       (fv_num),
        .stream_begin (stream_begin),
        .grant        (stream_grant),
        .rdata        (rdata),
        .want         (stream_want),
        .sram         (stream_sram),
        .sm_out       (sm_out)
    );

    fv_access_engine u_access (
        .clk      (clk),
        .reset    (reset),
        .fv_num   (fv_num),
        .req      (req),
        .grant    (access_grant),
        .rdata    (rdata),
        .want     (access_want),
        .sram     (access_sram),
        .edge_out (edge_out)
    );

    fv_bank_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .update_iter  (update_iter),
        .stream_want  (stream_want),
        .access_want  (access_want),
        .stream_sram  (stream_sram),
        .access_sram  (access_sram),
        .stream_grant (stream_grant),
        .access_grant (access_grant),
        .sram         (sram_req)
    );

    fv_sram_bank u_sram (
        .clk   (clk),
        .req   (sram_req),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: hdl/fv_sram_bank.sv
/* Single-port 256x64 SRAM model with active-low enables.
   Read data shows one cycle after the access; a write leaves rdata unchanged. */
`timescale 1ns/1ps
`default_nettype none

module fv_sram_bank (
    input  wire                                clk,
    input  wire fv_bank_pkg::sram_req_t        req,
    output logic [fv_bank_pkg::FV_DATA_W-1:0]  rdata
);
    import fv_bank_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    logic [FV_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!req.cen) begin
            if (!req.wen) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

    // Engine addresses reach here through the arbiter mux
    addr_known: assert property (@(posedge clk) !req.cen |-> !$isunknown(req.addr))
        else $error("SRAM access with unknown address %h", req.addr);

endmodule

`default_nettype wire

// File: hdl/fv_stream_engine.sv
/* Streams all lines of every node in one replay iteration to the small bank.
   stream_begin is sampled as a level; an iteration change stays pending until served. */
`timescale 1ns/1ps
`default_nettype none

module fv_stream_engine (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [fv_bank_pkg::ITER_W-1:0]      replay_iter,
    input  wire [fv_bank_pkg::FV_NUM_W-1:0]    fv_num,
    input  wire                                stream_begin,
    input  wire                                grant,
    input  wire [fv_bank_pkg::FV_DATA_W-1:0]   rdata,
    output logic                               want,
    output fv_bank_pkg::sram_req_t             sram,
    output fv_bank_pkg::sm_fv_beat_t           sm_out
);
    import fv_bank_pkg::*;

    logic                      busy;
    logic [ITER_W-1:0]         rec_iter;
    logic [ITER_W-1:0]         iter_q;
    logic [NODE_W-1:0]         node_cnt;
    logic [LINE_W-1:0]         line_cnt;
    logic [LINE_W:0]           lines_q;

    logic                      start_cond;
    logic                      issue;
    logic                      last_line;
    logic                      last_beat;
    logic [ITER_W-1:0]         cur_iter;
    logic [NODE_W-1:0]         cur_node;
    logic [LINE_W-1:0]         cur_line;
    logic [LINE_W:0]           cur_lines;

    // Beat flags trail the read by one cycle to meet rdata
    logic                      beat_valid;
    logic                      beat_sos;
    logic                      beat_eos;
    logic [NODE_W+LINE_W-1:0]  beat_a;

    assign start_cond = stream_begin || (replay_iter != rec_iter);
    assign want       = busy || start_cond;
    assign issue      = grant && want;

    // A new stream begins at line 0 of node 0
    always_comb begin
        if (busy) begin
            cur_iter  = iter_q;
            cur_node  = node_cnt;
            cur_line  = line_cnt;
            cur_lines = lines_q;
        end else begin
            cur_iter  = replay_iter;
            cur_node  = '0;
            cur_line  = '0;
            cur_lines = fv_num_lines(fv_num);
        end
    end

    assign last_line = ({1'b0, cur_line} == cur_lines - 1'b1);
    assign last_beat = last_line && (cur_node == NODE_W'(NODES_PER_ITER - 1));

    always_comb begin
        sram.cen                    = ~issue;
        sram.wen                    = 1'b1;
        sram.addr.stream_view.iter  = cur_iter;
        sram.addr.stream_view.node  = cur_node;
        sram.addr.stream_view.line  = cur_line;
        sram.wdata                  = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            rec_iter   <= '0;
            node_cnt   <= '0;
            line_cnt   <= '0;
            beat_valid <= 1'b0;
            beat_sos   <= 1'b0;
            beat_eos   <= 1'b0;
        end else begin
            beat_valid <= issue;
            beat_sos   <= issue && !busy;
            beat_eos   <= issue && last_beat;
            if (issue) begin
                busy     <= !last_beat;
                line_cnt <= last_line ? '0 : cur_line + 1'b1;
                node_cnt <= last_line ? cur_node + 1'b1 : cur_node;
                if (!busy) begin
                    rec_iter <= replay_iter;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        beat_a <= {cur_node, cur_line};
        if (issue) begin
            iter_q  <= cur_iter;
            lines_q <= cur_lines;
        end
    end

    always_comb begin
        sm_out.valid = beat_valid;
        sm_out.sos   = beat_sos;
        sm_out.eos   = beat_eos;
        sm_out.a     = beat_a;
        sm_out.data  = rdata;
    end

    // The stream engine only ever reads the bank
    read_only: assert property (@(posedge clk) disable iff (reset)
        !sram.cen |-> sram.wen)
        else $error("Stream engine issued a write");

endmodule

`default_nettype wire

// File: test/fv_bank_tb.sv
/* Directed tests of the feature-value bank against a reference memory of all 256 lines.
   Inputs change on rising edges; outputs are sampled on falling edges. */
`timescale 1ns/1ps
`default_nettype none

module fv_bank_tb;
    import fv_bank_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int BEAT_TIMEOUT  = 16;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // Bursts plus idle windows, in clock cycles
    localparam int TEST_CYCLES = 32 * (8 + 1) + 2 * (8 + 4) + 2 * (64 + 4) + 100
                               + 8 * (2 + 4 + 7) + (1 + 3 + 6) * (8 + 1 + 4) + 50;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD_NS;

    logic                  clk;
    logic                  reset;
    logic [ITER_W-1:0]     replay_iter;
    logic [UPD_W-1:0]      update_iter;
    logic [FV_NUM_W-1:0]   fv_num;
    logic                  stream_begin;
    out_req_t              req;
    sm_fv_beat_t           sm_out;
    edge_rd_beat_t         edge_out;

    logic [FV_DATA_W-1:0]  ref_mem [1 << ADDR_W];
    logic [31:0]           lfsr_state;
    int                    fail_count;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    fv_bank_top dut (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .fv_num       (fv_num),
        .stream_begin (stream_begin),
        .req          (req),
        .sm_out       (sm_out),
        .edge_out     (edge_out)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_POLY;
        end
        return s >> 1;
    endfunction

    // One LFSR step per data bit
    function automatic logic [FV_DATA_W-1:0] random_word();
        logic [FV_DATA_W-1:0] word;
        word = '0;
        for (int i = 0; i < FV_DATA_W; i++) begin
            word       = {word[FV_DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return word;
    endfunction

    task automatic stop_with_failure();
        fail_count++;
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: %s expected %h got %h", name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic expect_outputs_low();
        expect_equal("sm_out.valid", sm_out.valid, 1'b0);
        expect_equal("sm_out.sos", sm_out.sos, 1'b0);
        expect_equal("sm_out.eos", sm_out.eos, 1'b0);
        expect_equal("edge_out.valid", edge_out.valid, 1'b0);
        expect_equal("edge_out.sos", edge_out.sos, 1'b0);
        expect_equal("edge_out.eos", edge_out.eos, 1'b0);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            expect_outputs_low();
        end
    endtask

    // Toggles the mode by stepping the update iteration
    task automatic set_mode(input logic odd);
        @(posedge clk);
        if (update_iter[0] != odd) begin
            update_iter <= update_iter + 1'b1;
        end
    endtask

    task automatic write_node(input logic [NODE_ID_W-1:0] node_id, input int lines);
        out_req_t             beat;
        logic [FV_DATA_W-1:0] word;
        for (int k = 0; k < lines; k++) begin
            @(posedge clk);
            word         = random_word();
            beat         = '0;
            beat.valid   = 1'b1;
            beat.rd_wr   = 1'b1;
            beat.wr_eos  = (k == lines - 1);
            beat.node_id = node_id;
            beat.data    = word;
            req <= beat;
            ref_mem[{node_id, LINE_W'(k)}] = word;
        end
        @(posedge clk);
        beat = '0;
        req <= beat;
    endtask

    task automatic send_read(input logic [NODE_ID_W-1:0] node_id,
                             input logic [PE_TAG_W-1:0] tag);
        out_req_t beat;
        @(posedge clk);
        beat         = '0;
        beat.valid   = 1'b1;
        beat.node_id = node_id;
        beat.pe_tag  = tag;
        req <= beat;
    endtask

    // Drops the request after its accept cycle, then checks every beat
    task automatic collect_edge_burst(input logic [NODE_ID_W-1:0] node_id,
                                      input logic [PE_TAG_W-1:0] tag, input int lines);
        out_req_t idle_req;
        int       wait_cycles;
        idle_req = '0;
        @(posedge clk);
        req <= idle_req;
        wait_cycles = 0;
        @(negedge clk);
        while (!edge_out.valid) begin
            wait_cycles++;
            assert (wait_cycles < BEAT_TIMEOUT) else begin
                $display("Timed out waiting for an edge read beat");
                stop_with_failure();
            end
            @(negedge clk);
        end
        assert (wait_cycles == 0) else begin
            $display("First edge read beat came %0d cycles late", wait_cycles);
            stop_with_failure();
        end
        for (int k = 0; k < lines; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            expect_equal("edge_out.valid", edge_out.valid, 1'b1);
            expect_equal("edge_out.sos", edge_out.sos, k == 0);
            expect_equal("edge_out.eos", edge_out.eos, k == lines - 1);
            expect_equal("edge_out.pe_tag", edge_out.pe_tag, tag);
            expect_equal("edge_out.data", edge_out.data, ref_mem[{node_id, LINE_W'(k)}]);
        end
        @(negedge clk);
        expect_equal("edge_out.valid", edge_out.valid, 1'b0);
    endtask

    // New iteration triggers by itself, the same one needs stream_begin
    task automatic start_stream(input logic [ITER_W-1:0] iter);
        @(posedge clk);
        if (iter != replay_iter) begin
            replay_iter <= iter;
        end else begin
            stream_begin <= 1'b1;
        end
    endtask

    task automatic collect_stream(input logic [ITER_W-1:0] iter, input int lines);
        int                       wait_cycles;
        int                       beats;
        logic [NODE_W+LINE_W-1:0] a_exp;
        @(posedge clk);
        stream_begin <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!sm_out.valid) begin
            wait_cycles++;
            assert (wait_cycles < BEAT_TIMEOUT) else begin
                $display("Timed out waiting for a stream beat");
                stop_with_failure();
            end
            @(negedge clk);
        end
        assert (wait_cycles == 0) else begin
            $display("First stream beat came %0d cycles late", wait_cycles);
            stop_with_failure();
        end
        beats = NODES_PER_ITER * lines;
        for (int k = 0; k < beats; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            a_exp = {NODE_W'(k / lines), LINE_W'(k % lines)};
            expect_equal("sm_out.valid", sm_out.valid, 1'b1);
            expect_equal("sm_out.sos", sm_out.sos, k == 0);
            expect_equal("sm_out.eos", sm_out.eos, k == beats - 1);
            expect_equal("sm_out.a", sm_out.a, a_exp);
            expect_equal("sm_out.data", sm_out.data, ref_mem[{iter, a_exp}]);
        end
        @(negedge clk);
        expect_equal("sm_out.valid", sm_out.valid, 1'b0);
    endtask

    task automatic reset_and_idle();
        @(posedge clk);
        while (reset) begin
            @(negedge clk);
            expect_outputs_low();
        end
        expect_quiet(16);
    endtask

    task automatic write_back_and_read();
        set_mode(1'b1);
        for (int n = 0; n < 32; n++) begin
            write_node(NODE_ID_W'(n), 8);
        end
        send_read(5'd13, 2'd2);
        collect_edge_burst(5'd13, 2'd2, 8);
        send_read(5'd30, 2'd1);
        collect_edge_burst(5'd30, 2'd1, 8);
    endtask

    task automatic stream_on_begin();
        set_mode(1'b0);
        start_stream(replay_iter);
        collect_stream(replay_iter, 8);
    endtask

    task automatic stream_on_iter_change();
        start_stream(2'd2);
        collect_stream(2'd2, 8);
        // Same iteration and no stream_begin
        expect_quiet(20);
    endtask

    task automatic mode_gating();
        set_mode(1'b1);
        @(posedge clk);
        stream_begin <= 1'b1;
        @(posedge clk);
        stream_begin <= 1'b0;
        expect_quiet(16);
        // Read held through the even mode, answered once the mode is odd
        set_mode(1'b0);
        send_read(5'd7, 2'd3);
        expect_quiet(10);
        set_mode(1'b1);
        collect_edge_burst(5'd7, 2'd3, 8);
    endtask

    task automatic short_vectors(input logic [FV_NUM_W-1:0] num,
                                 input logic [ITER_W-1:0] iter);
        int lines;
        lines = (num + 1) / 2;
        set_mode(1'b1);
        @(posedge clk);
        fv_num <= num;
        for (int n = 0; n < NODES_PER_ITER; n++) begin
            write_node({iter, NODE_W'(n)}, lines);
        end
        send_read({iter, 3'd5}, PE_TAG_W'(num));
        collect_edge_burst({iter, 3'd5}, PE_TAG_W'(num), lines);
        set_mode(1'b0);
        start_stream(iter);
        collect_stream(iter, lines);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        stop_with_failure();
    end

    initial begin
        fail_count   = 0;
        lfsr_state   = 32'd30;
        replay_iter  = '0;
        update_iter  = '0;
        fv_num       = 5'd16;
        stream_begin = 1'b0;
        req          = '0;

        reset_and_idle();
        write_back_and_read();
        stream_on_begin();
        stream_on_iter_change();
        mode_gating();
        short_vectors(5'd1, 2'd1);
        short_vectors(5'd5, 2'd3);
        short_vectors(5'd12, 2'd0);

        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
/* Free-running testbench clock and a synchronous reset held for RESET_CYCLES edges. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
